// File: source/qspi_pkg.sv
package qspi_pkg;

  // ************************************************************************
  // Serial clock
  // ************************************************************************

  // System clocks per serial half period, minus one.
  localparam int half_period = 1;

  // ************************************************************************
  // Transfer shape
  // ************************************************************************

  localparam int data_bits    = 64;
  localparam int nibble_count = 16;
  localparam int count_bits   = 5; // Holds 0 to 16.

  // ************************************************************************
  // Bus and register map
  // ************************************************************************

  localparam int address_bits = 32;
  localparam int strobe_bits  = 8;

  localparam logic [address_bits-1:0] data_address   = 32'h0000_0000;
  localparam logic [address_bits-1:0] status_address = 32'h0000_0008;

endpackage

// File: source/qspi_clock_gen.sv
`timescale 1ns/1ps

module qspi_clock_gen
  import qspi_pkg::*;
(
  input  logic clock,
  input  logic reset,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  logic [3:0] half_count;
  logic       half_done;

  assign half_done = (half_count == 4'(half_period));

  // The strobes are registered with sclk, so each one is high in the
  // first system cycle that sees the new sclk level.
  always_ff @(posedge clock) begin
    if (!reset) begin
      half_count <= '0;
      sclk       <= 1'b0; // Idles low.
      sclk_rise  <= 1'b0;
      sclk_fall  <= 1'b0;
    end else begin
      if (half_done) begin
        half_count <= '0;
        sclk       <= ~sclk;
        sclk_rise  <= ~sclk;
        sclk_fall  <= sclk;
      end else begin
        half_count <= half_count + 4'd1;
        sclk_rise  <= 1'b0;
        sclk_fall  <= 1'b0;
      end
    end
  end

endmodule

// File: source/qspi_shifter.sv
`timescale 1ns/1ps

module qspi_shifter
  import qspi_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 sclk_rise,
  input  logic                 sclk_fall,
  input  logic                 start_write,
  input  logic                 start_read,
  input  logic [data_bits-1:0] write_word,
  input  logic [3:0]           in_nibble,
  output logic [3:0]           out_nibble,
  output logic                 drive_enable,
  output logic                 cs,
  output logic                 busy,
  output logic                 done,
  output logic [data_bits-1:0] read_word
);

  logic [data_bits-1:0]  shift_reg;
  logic [count_bits-1:0] nibble_index;
  logic                  mode_read;
  logic                  armed;     // Frame has settled for one cycle.
  logic                  sampled;   // A rise was seen since the last fall.
  logic                  last_seen;
  logic                  take_rise;
  logic                  take_fall;

  assign last_seen = (nibble_index == count_bits'(nibble_count));

  // A rise in the first busy cycle coincides with cs falling, so it is
  // not counted as a device sample.
  assign take_rise = busy && armed && sclk_rise && !last_seen;
  assign take_fall = busy && sclk_fall && sampled;

  assign out_nibble = shift_reg[3:0]; // LS nibble goes out first.
  assign read_word  = shift_reg;

  // ************************************************************************
  // Frame control
  // ************************************************************************

  always_ff @(posedge clock) begin
    if (!reset) begin
      cs           <= 1'b1;
      busy         <= 1'b0;
      done         <= 1'b0;
      drive_enable <= 1'b0;
      mode_read    <= 1'b0;
      nibble_index <= '0;
      armed        <= 1'b0;
      sampled      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start_write || start_read) begin
          busy         <= 1'b1;
          cs           <= 1'b0;
          mode_read    <= start_read;
          drive_enable <= start_write;
          nibble_index <= '0;
          armed        <= 1'b0;
          sampled      <= 1'b0;
        end
      end else begin
        armed <= 1'b1;
        if (take_rise) begin
          nibble_index <= nibble_index + 1'b1;
          sampled      <= 1'b1;
        end else if (take_fall) begin
          sampled <= 1'b0;
          if (last_seen) begin // Close on the fall after nibble 16.
            cs           <= 1'b1;
            busy         <= 1'b0;
            drive_enable <= 1'b0;
            done         <= 1'b1;
          end
        end
      end
    end
  end

  // ************************************************************************
  // Data path
  // ************************************************************************

  always_ff @(posedge clock) begin
    if (!busy && start_write) begin
      shift_reg <= write_word;
    end else if (take_rise && mode_read) begin
      shift_reg <= {shift_reg[data_bits-5:0], in_nibble}; // MS nibble arrives first.
    end else if (take_fall && !mode_read && !last_seen) begin
      shift_reg <= {4'b0000, shift_reg[data_bits-1:4]};
    end
  end

endmodule

// File: source/qspi_bus_port.sv
`timescale 1ns/1ps

module qspi_bus_port
  import qspi_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    mem_valid,
  input  logic [address_bits-1:0] mem_addr,
  input  logic [data_bits-1:0]    mem_wdata,
  input  logic [strobe_bits-1:0]  mem_wstrb,
  output logic [data_bits-1:0]    mem_rdata,
  output logic                    mem_ready,
  input  logic                    busy,
  input  logic                    done,
  input  logic [data_bits-1:0]    read_word,
  output logic                    start_write,
  output logic                    start_read,
  output logic [data_bits-1:0]    write_word
);

  logic data_hit;
  logic status_hit;
  logic is_write;
  logic pending;      // Transfer running for the held request.
  logic pending_read;
  logic start_now;
  logic answer_now;

  assign data_hit   = (mem_addr == data_address);
  assign status_hit = (mem_addr == status_address);
  assign is_write   = |mem_wstrb;

  // A held data request waits here until the shifter is idle.
  assign start_now  = mem_valid && data_hit && !pending && !busy && !mem_ready
                      && !start_write && !start_read;
  assign answer_now = mem_valid && !data_hit && !mem_ready && !done;

  always_ff @(posedge clock) begin
    if (!reset) begin
      start_write  <= 1'b0;
      start_read   <= 1'b0;
      pending      <= 1'b0;
      pending_read <= 1'b0;
      mem_ready    <= 1'b0;
    end else begin
      start_write <= start_now && is_write;
      start_read  <= start_now && !is_write;
      mem_ready   <= 1'b0;
      if (start_now) begin
        pending      <= 1'b1;
        pending_read <= !is_write;
      end else if (done && pending) begin
        pending   <= 1'b0;
        mem_ready <= 1'b1;
      end else if (answer_now) begin
        mem_ready <= 1'b1; // Status and unmapped answer at once.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start_now) begin
      write_word <= mem_wdata;
    end
    if (done && pending) begin
      mem_rdata <= pending_read ? read_word : '0;
    end else if (answer_now) begin
      mem_rdata <= status_hit ? {{(data_bits-1){1'b0}}, busy} : '0;
    end
  end

endmodule

// File: source/qspi_top.sv
`timescale 1ns/1ps

module qspi_top
  import qspi_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    mem_valid,
  input  logic [address_bits-1:0] mem_addr,
  input  logic [data_bits-1:0]    mem_wdata,
  input  logic [strobe_bits-1:0]  mem_wstrb,
  output logic [data_bits-1:0]    mem_rdata,
  output logic                    mem_ready,
  output logic                    sclk,
  output logic                    cs,
  inout  wire                     d0,
  inout  wire                     d1,
  inout  wire                     d2,
  inout  wire                     d3
);

  logic                 sclk_rise;
  logic                 sclk_fall;
  logic                 start_write;
  logic                 start_read;
  logic [data_bits-1:0] write_word;
  logic [data_bits-1:0] read_word;
  logic                 busy;
  logic                 done;
  logic                 drive_enable;
  logic [3:0]           out_nibble;
  logic [3:0]           in_nibble;

  qspi_clock_gen clock_gen (
    .clock, .reset, .sclk, .sclk_rise, .sclk_fall
  );

  qspi_shifter shifter (
    .clock, .reset, .sclk_rise, .sclk_fall, .start_write, .start_read,
    .write_word, .in_nibble, .out_nibble, .drive_enable, .cs, .busy,
    .done, .read_word
  );

  qspi_bus_port bus_port (
    .clock, .reset, .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb,
    .mem_rdata, .mem_ready, .busy, .done, .read_word, .start_write,
    .start_read, .write_word
  );

  // ************************************************************************
  // Pads
  // ************************************************************************

  assign d0 = drive_enable ? out_nibble[0] : 1'bz;
  assign d1 = drive_enable ? out_nibble[1] : 1'bz;
  assign d2 = drive_enable ? out_nibble[2] : 1'bz;
  assign d3 = drive_enable ? out_nibble[3] : 1'bz;

  assign in_nibble = {d3, d2, d1, d0}; // Released lines read the device.

endmodule

// File: verification/qspi_checker.sv
`timescale 1ns/1ps

module qspi_checker
  import qspi_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic cs,
  input logic busy,
  input logic drive_enable,
  input logic mode_read,
  input logic done
);

  logic [7:0] low_cycles; // Cycles cs has been low in this frame.

  always_ff @(posedge clock) begin
    if (!reset || cs) begin
      low_cycles <= '0;
    end else begin
      low_cycles <= low_cycles + 8'd1;
    end
  end

  // **************************************************************************
  // Frame rules
  // **************************************************************************

  // A frame spans sixteen full serial periods.
  frame_full_length : assert property (
    @(posedge clock) disable iff (!reset)
    $rose(cs) |-> (low_cycles >= 8'(nibble_count * 2 * (half_period + 1)))
  ) else $error("cs rose before a full frame");

  no_drive_in_read : assert property (
    @(posedge clock) disable iff (!reset)
    !(drive_enable && mode_read)
  ) else $error("pads driven during a read frame");

  done_single_cycle : assert property (
    @(posedge clock) disable iff (!reset)
    done |=> !done
  ) else $error("done held longer than one cycle");

endmodule

bind qspi_shifter qspi_checker checker_inst (
  .clock        (clock),
  .reset        (reset),
  .cs           (cs),
  .busy         (busy),
  .drive_enable (drive_enable),
  .mode_read    (mode_read),
  .done         (done)
);

// File: verification/qspi_tb.sv
`timescale 1ns/1ps

module qspi_tb
  import qspi_pkg::*;
;

  logic                    clock;
  logic                    reset;
  logic                    mem_valid;
  logic [address_bits-1:0] mem_addr;
  logic [data_bits-1:0]    mem_wdata;
  logic [strobe_bits-1:0]  mem_wstrb;
  logic [data_bits-1:0]    mem_rdata;
  logic                    mem_ready;
  logic                    sclk;
  logic                    cs;
  wire                     d0;
  wire                     d1;
  wire                     d2;
  wire                     d3;

  logic [63:0] test_mem [0:127];
  int          test_count;
  int          cycle_count;
  int          cycle_limit;

  // Device model state.
  logic                 model_read;
  logic [data_bits-1:0] model_word;
  logic [3:0]           model_nibble;
  logic [data_bits-1:0] cap_word;
  int                   cap_idx;
  int                   read_idx;
  int                   frame_count;
  logic                 rise_pending;
  time                  cs_fall_time;

  qspi_top dut (
    .clock, .reset, .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb,
    .mem_rdata, .mem_ready, .sclk, .cs, .d0, .d1, .d2, .d3
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // **************************************************************************
  // Quad-SPI device model
  // **************************************************************************

  assign d0 = (model_read && !cs) ? model_nibble[0] : 1'bz;
  assign d1 = (model_read && !cs) ? model_nibble[1] : 1'bz;
  assign d2 = (model_read && !cs) ? model_nibble[2] : 1'bz;
  assign d3 = (model_read && !cs) ? model_nibble[3] : 1'bz;

  always @(negedge cs) begin
    cs_fall_time = $time;
    cap_idx      = 0;
    cap_word     = '0;
    read_idx     = 0;
    rise_pending = 1'b0;
    model_nibble = model_word[63:60]; // MS nibble first.
    frame_count  = frame_count + 1;
  end

  // A rise at the same instant cs falls is not a sample edge.
  always @(posedge sclk) begin : capture_rise
    time rise_time;
    rise_time = $time;
    #1;
    if (!cs && cs_fall_time < rise_time) begin
      rise_pending = 1'b1;
      if (!model_read && cap_idx < nibble_count) begin
        cap_word[cap_idx*4 +: 4] = {d3, d2, d1, d0};
        cap_idx = cap_idx + 1;
      end
    end
  end

  always @(negedge sclk) begin
    #1;
    if (!cs && rise_pending) begin
      rise_pending = 1'b0;
      read_idx = read_idx + 1;
      if (read_idx < nibble_count) begin
        model_nibble = model_word[63-read_idx*4 -: 4];
      end
    end
  end

  // **************************************************************************
  // Run limit
  // **************************************************************************

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Run exceeded its cycle limit of %0d without finishing", cycle_limit);
      $display("Regression failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
      $display("Regression failed");
      $fatal(1, "compare failed");
    end
  endtask

  task automatic step();
    @(posedge clock);
    #2;
  endtask

  task automatic start_request(input logic [31:0] addr, input logic [63:0] wdata,
                               input logic [7:0] wstrb);
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
  endtask

  task automatic wait_ready(input bit keep_cs_high);
    bit seen;
    seen = 1'b0;
    while (!seen) begin
      step();
      if (keep_cs_high) check_value("cs", 64'(cs), 64'd1);
      seen = mem_ready;
    end
  endtask

  task automatic end_request();
    mem_valid = 1'b0;
    mem_wstrb = '0;
    step();
    check_value("mem_ready", 64'(mem_ready), 64'd0); // One-cycle pulse.
  endtask

  task automatic wait_cs_low();
    while (cs) step();
  endtask

  task automatic run_test(input logic [3:0] op, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [63:0] expected);
    int frames_before;
    frames_before = frame_count;
    case (op)
      4'd0: begin // Write.
        model_read = 1'b0;
        start_request(addr, wdata, 8'hff);
        wait_ready(1'b0);
        check_value("cs", 64'(cs), 64'd1);
        end_request();
        check_value("write nibbles", cap_word, expected);
        check_value("frames", 64'(frame_count - frames_before), 64'd1);
      end
      4'd1: begin // Read.
        model_read = 1'b1;
        model_word = expected;
        start_request(addr, wdata, 8'h00);
        wait_ready(1'b0);
        check_value("mem_rdata", mem_rdata, expected);
        end_request();
      end
      4'd2, 4'd3: begin // Status or unmapped.
        start_request(addr, wdata, (wdata != 0) ? 8'hff : 8'h00);
        wait_ready(1'b1);
        check_value("mem_rdata", mem_rdata, expected);
        end_request();
        check_value("frames", 64'(frame_count - frames_before), 64'd0);
      end
      4'd4: begin // Status read while a write runs.
        model_read = 1'b0;
        start_request(addr, wdata, 8'hff);
        wait_cs_low();
        mem_valid = 1'b0;
        step();
        start_request(status_address, '0, 8'h00);
        wait_ready(1'b0);
        check_value("mem_rdata", mem_rdata, expected);
        end_request();
        while (!mem_ready) step(); // Ready of the earlier write.
        check_value("write nibbles", cap_word, wdata);
      end
      4'd5: begin // Read queued behind a running write.
        model_read = 1'b0;
        start_request(addr, wdata, 8'hff);
        wait_cs_low();
        mem_valid = 1'b0;
        start_request(data_address, '0, 8'h00);
        while (!cs) begin
          check_value("mem_ready", 64'(mem_ready), 64'd0);
          step();
        end
        while (!mem_ready) step();
        check_value("write nibbles", cap_word, wdata);
        model_read = 1'b1;
        model_word = expected;
        wait_ready(1'b0);
        check_value("mem_rdata", mem_rdata, expected);
        check_value("frames", 64'(frame_count - frames_before), 64'd2);
        end_request();
      end
      default: begin
        $display("Test file holds an unknown operation code %0d", op);
        $display("Regression failed");
        $fatal(1, "bad operation code");
      end
    endcase
  endtask

  // **************************************************************************
  // Main sequence
  // **************************************************************************

  initial begin
    int unsigned gap;
    reset        = 1'b0;
    mem_valid    = 1'b0;
    mem_addr     = '0;
    mem_wdata    = '0;
    mem_wstrb    = '0;
    model_read   = 1'b0;
    model_word   = '0;
    model_nibble = '0;
    cap_word     = '0;
    cap_idx      = 0;
    read_idx     = 0;
    frame_count  = 0;
    rise_pending = 1'b0;
    cs_fall_time = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    void'($urandom(32'h5954));

    for (int i = 0; i < 128; i++) test_mem[i] = '1;
    $readmemh("verification/qspi_input.txt", test_mem);
    test_count = 0;
    while (test_count < 32 && test_mem[test_count*4] != '1) test_count++;
    cycle_limit = 400 * test_count;

    repeat (3) @(posedge clock);
    #2;
    reset = 1'b1;
    check_value("cs", 64'(cs), 64'd1);
    check_value("sclk", 64'(sclk), 64'd0);
    check_value("mem_ready", 64'(mem_ready), 64'd0);
    check_value("drive_enable", 64'(dut.shifter.drive_enable), 64'd0);

    for (int i = 0; i < test_count; i++) begin
      run_test(test_mem[i*4][3:0], test_mem[i*4+1][31:0], test_mem[i*4+2],
               test_mem[i*4+3]);
      gap = $urandom % 6;
      repeat (gap) step();
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// File: verification/qspi_input.txt
// op address write_word expected
// op: 0 write, 1 read, 2 status, 3 unmapped, 4 status during write, 5 read behind write
0 00000000 0123456789abcdef 0123456789abcdef
1 00000000 0000000000000000 fedcba9876543210
2 00000008 0000000000000000 0000000000000000
3 00000010 0000000000000000 0000000000000000
3 00000004 0000000000005555 0000000000000000
4 00000000 a5a5a5a5deadbeef 0000000000000001
5 00000000 1122334455667788 8899aabbccddeeff
0 00000000 ffffffffffffffff ffffffffffffffff
1 00000000 0000000000000000 0000000000000000
0 00000000 0000000000000000 0000000000000000
1 00000000 0000000000000000 ffffffffffffffff
2 00000008 0000000000000000 0000000000000000
4 00000000 0f0f0f0f0f0f0f0f 0000000000000001
5 00000000 8000000000000001 123456789abcdef0
3 ffff0000 0000000000000000 0000000000000000
0 00000000 c3c3c3c33c3c3c3c c3c3c3c33c3c3c3c
1 00000000 0000000000000000 a5a55a5a0ff0f00f
2 00000008 0000000000000000 0000000000000000
5 00000000 0000000000000001 7fffffffffffffff
0 00000000 13579bdf02468ace 13579bdf02468ace
1 00000000 0000000000000000 0000000000000001
3 0000000c 1234000000000000 0000000000000000

// File: qspi_subsystem.f
source/qspi_pkg.sv
source/qspi_clock_gen.sv
source/qspi_shifter.sv
source/qspi_bus_port.sv
source/qspi_top.sv
verification/qspi_checker.sv
verification/qspi_tb.sv

// File: Makefile
# Verilator build and run for the quad-SPI subsystem.

VERILATOR ?= verilator
TOP       ?= qspi_tb
BUILD_DIR ?= build
FILE_LIST ?= qspi_subsystem.f

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
DATA    := verification/qspi_input.txt
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary --timing --assert \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) \
		-f $(FILE_LIST)

run: $(BINARY) $(DATA)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
